/* Makefile */
# Verilator build and run for the writeback control testbench

SIM       = verilator
TOP       = wb_ctl_tb
FILELIST  = tb.f
SIM_FLAGS = --binary --timing --assert -j 0
RUN_FLAGS = +verilator+error+limit+100
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
PASS_MSG  = No errors
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(RUN_FLAGS) | tee $(LOG)
	grep -qx '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/wb_ctl_top.sv */
// writeback control top for the four-thread integer unit register file ports
`timescale 1ns/1ps
`default_nettype none

module wb_ctl_top import wb_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   // pipeline
   input  logic      wen_d,
   input  logic      kill_e,
   input  logic      inst_vld_e,
   input  logic      inst_vld_w,
   input  logic      flush_w,
   input  logic      restore_e,
   input  reg_addr_t rd_m,
   input  tid_t      tid_m,
   // load return
   input  logic      ld_vld_g,
   input  reg_addr_t ld_rd_g,
   input  tid_t      ld_tid_g,
   input  logic      ld_miss_g2,
   // mul/div results
   input  logic      md_req_g,
   input  logic      md_sel_div,
   input  reg_addr_t md_div_rd_g,
   input  tid_t      md_div_tid_g,
   input  reg_addr_t md_mul_rd_g,
   input  tid_t      md_mul_tid_g,
   // W1 port
   output reg_addr_t w1_rd_m,
   output tid_t      w1_tid_m,
   output logic      w1_wen_w,
   // G port
   output reg_addr_t w2_rd_g,
   output tid_t      w2_tid_g,
   output logic      w2_wen_w2,
   output logic      md_ack_g,
   output thr_mask_t longop_done_g
);

   logic      wb_e;
   logic      wb_m;
   logic      pipe_wen_w;
   logic      ld_g2;
   logic      ld_wen_g2;
   reg_addr_t ld_rd_g2;
   tid_t      ld_tid_g2;
   logic      restore_req;
   logic      restore_wen;
   reg_addr_t restore_rd;
   tid_t      restore_tid;
   thr_mask_t restore_done;
   logic      restore_pick;

   wb_pipe_valid u_pipe_valid (
      .clk        (clk),
      .rst_n      (rst_n),
      .wen_d      (wen_d),
      .kill_e     (kill_e),
      .restore_e  (restore_e),
      .flush_w    (flush_w),
      .inst_vld_w (inst_vld_w),
      .wb_e       (wb_e),
      .wb_m       (wb_m),
      .pipe_wen_w (pipe_wen_w)
   );

   wb_load_stage u_load_stage (
      .clk        (clk),
      .rst_n      (rst_n),
      .ld_vld_g   (ld_vld_g),
      .ld_rd_g    (ld_rd_g),
      .ld_tid_g   (ld_tid_g),
      .ld_miss_g2 (ld_miss_g2),
      .ld_g2      (ld_g2),
      .ld_wen_g2  (ld_wen_g2),
      .ld_rd_g2   (ld_rd_g2),
      .ld_tid_g2  (ld_tid_g2)
   );

   wb_restore_fsm u_restore_fsm (
      .clk          (clk),
      .rst_n        (rst_n),
      .restore_e    (restore_e),
      .wb_e         (wb_e),
      .inst_vld_e   (inst_vld_e),
      .inst_vld_w   (inst_vld_w),
      .flush_w      (flush_w),
      .rd_m         (rd_m),
      .tid_m        (tid_m),
      .restore_pick (restore_pick),
      .restore_req  (restore_req),
      .restore_wen  (restore_wen),
      .restore_rd   (restore_rd),
      .restore_tid  (restore_tid),
      .restore_done (restore_done)
   );

   wb_port_arbiter u_port_arbiter (
      .clk           (clk),
      .rst_n         (rst_n),
      .wb_m          (wb_m),
      .pipe_wen_w    (pipe_wen_w),
      .rd_m          (rd_m),
      .tid_m         (tid_m),
      .ld_g2         (ld_g2),
      .ld_wen_g2     (ld_wen_g2),
      .ld_rd_g2      (ld_rd_g2),
      .ld_tid_g2     (ld_tid_g2),
      .restore_req   (restore_req),
      .restore_wen   (restore_wen),
      .restore_rd    (restore_rd),
      .restore_tid   (restore_tid),
      .restore_done  (restore_done),
      .md_req_g      (md_req_g),
      .md_sel_div    (md_sel_div),
      .md_div_rd_g   (md_div_rd_g),
      .md_div_tid_g  (md_div_tid_g),
      .md_mul_rd_g   (md_mul_rd_g),
      .md_mul_tid_g  (md_mul_tid_g),
      .restore_pick  (restore_pick),
      .w1_rd_m       (w1_rd_m),
      .w1_tid_m      (w1_tid_m),
      .w1_wen_w      (w1_wen_w),
      .w2_rd_g       (w2_rd_g),
      .w2_tid_g      (w2_tid_g),
      .w2_wen_w2     (w2_wen_w2),
      .md_ack_g      (md_ack_g),
      .longop_done_g (longop_done_g)
   );

endmodule : wb_ctl_top

`default_nettype wire

/* design/wb_load_stage.sv */
// load return staging that carries a returned load into G2 and drops its write on a miss
`timescale 1ns/1ps
`default_nettype none

module wb_load_stage import wb_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  logic      ld_vld_g,
   input  reg_addr_t ld_rd_g,
   input  tid_t      ld_tid_g,
   input  logic      ld_miss_g2,
   output logic      ld_g2,
   output logic      ld_wen_g2,
   output reg_addr_t ld_rd_g2,
   output tid_t      ld_tid_g2
);

   // occupancy flag for the port, held even when the load turns out to miss
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ld_g2 <= 1'b0;
      end else begin
         ld_g2 <= ld_vld_g;
      end
   end

   // destination of the returning load
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ld_rd_g2  <= '0;
         ld_tid_g2 <= '0;
      end else begin
         ld_rd_g2  <= ld_rd_g;
         ld_tid_g2 <= ld_tid_g;
      end
   end

   // miss arrives a cycle late, so it only removes the write and not the slot
   assign ld_wen_g2 = ld_g2 & ~ld_miss_g2;

endmodule : wb_load_stage

`default_nettype wire

/* design/wb_pipe_valid.sv */
// pipeline write enable staging from D to W with kill, restore and flush qualification
`timescale 1ns/1ps
`default_nettype none

module wb_pipe_valid (
   input  logic clk,
   input  logic rst_n,
   input  logic wen_d,
   input  logic kill_e,
   input  logic restore_e,
   input  logic flush_w,
   input  logic inst_vld_w,
   output logic wb_e,
   output logic wb_m,
   output logic pipe_wen_w
);

   logic valid_e;
   logic wb_w;

   // restores finish late through their own FSM, so they leave the pipe path here
   assign valid_e = wb_e & ~kill_e & ~restore_e;

   //////////////////////////////////////////////////////////////////////
   // stage flops, one write can sit in each of E, M and W
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wb_e <= 1'b0;
      end else begin
         wb_e <= wen_d;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wb_m <= 1'b0;
      end else begin
         wb_m <= valid_e;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wb_w <= 1'b0;
      end else begin
         wb_w <= wb_m;
      end
   end

   // inst valid and flush only become known in W
   assign pipe_wen_w = wb_w & ~flush_w & inst_vld_w;

endmodule : wb_pipe_valid

`default_nettype wire

/* design/wb_pkg.sv */
// writeback control package with widths, thread count and restore FSM states
`default_nettype none

package wb_pkg;

   //////////////////////////////////////////////////////////////////////
   // sizes
   //////////////////////////////////////////////////////////////////////

   // four hardware threads share the execution unit
   localparam int NUM_THREADS = 4;

   // integer register number within the current window
   localparam int REG_ADDR_W = 5;

   // thread id wide enough for NUM_THREADS
   localparam int TID_W = 2;

   //////////////////////////////////////////////////////////////////////
   // types
   //////////////////////////////////////////////////////////////////////

   typedef logic [REG_ADDR_W-1:0]  reg_addr_t;
   typedef logic [TID_W-1:0]       tid_t;

   // one bit per thread, bit n belongs to thread n
   typedef logic [NUM_THREADS-1:0] thr_mask_t;

   // restore tracking from E through W and then waiting for a port
   typedef enum logic [1:0] {
      rs_idle  = 2'd0,
      rs_m     = 2'd1,
      rs_w     = 2'd2,
      rs_ready = 2'd3
   } restore_state_t;

endpackage : wb_pkg

`default_nettype wire

/* design/wb_port_arbiter.sv */
// write port arbiter for W1 and G with enable staging, mul/div ack and long-op done
`timescale 1ns/1ps
`default_nettype none

module wb_port_arbiter import wb_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  logic      wb_m,
   input  logic      pipe_wen_w,
   input  reg_addr_t rd_m,
   input  tid_t      tid_m,
   input  logic      ld_g2,
   input  logic      ld_wen_g2,
   input  reg_addr_t ld_rd_g2,
   input  tid_t      ld_tid_g2,
   input  logic      restore_req,
   input  logic      restore_wen,
   input  reg_addr_t restore_rd,
   input  tid_t      restore_tid,
   input  thr_mask_t restore_done,
   input  logic      md_req_g,
   input  logic      md_sel_div,
   input  reg_addr_t md_div_rd_g,
   input  tid_t      md_div_tid_g,
   input  reg_addr_t md_mul_rd_g,
   input  tid_t      md_mul_tid_g,
   output logic      restore_pick,
   output reg_addr_t w1_rd_m,
   output tid_t      w1_tid_m,
   output logic      w1_wen_w,
   output reg_addr_t w2_rd_g,
   output tid_t      w2_tid_g,
   output logic      w2_wen_w2,
   output logic      md_ack_g,
   output thr_mask_t longop_done_g
);

   logic      sel_load_m;
   logic      sel_restore_m;
   logic      sel_load_g;
   logic      sel_restore_g;
   logic      sel_md_g;
   logic      w1_nopipe_wen_m;
   logic      w1_nopipe_wen_w;
   logic      w2_wen_g;
   reg_addr_t md_rd_g;
   tid_t      md_tid_g;
   thr_mask_t md_done_g;

   //////////////////////////////////////////////////////////////////////
   // W1 port, pipe first, then load, then restore
   //////////////////////////////////////////////////////////////////////

   assign sel_load_m    = ~wb_m & ld_g2;
   assign sel_restore_m = ~wb_m & ~ld_g2 & restore_req;

   // restore fields are the idle default when neither pipe nor load is present
   assign w1_rd_m  = wb_m ? rd_m  : (ld_g2 ? ld_rd_g2  : restore_rd);
   assign w1_tid_m = wb_m ? tid_m : (ld_g2 ? ld_tid_g2 : restore_tid);

   assign w1_nopipe_wen_m = (sel_load_m & ld_wen_g2) | (sel_restore_m & restore_wen);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         w1_nopipe_wen_w <= 1'b0;
      end else begin
         w1_nopipe_wen_w <= w1_nopipe_wen_m;
      end
   end

   // pipe write is already qualified in W by the stage logic
   assign w1_wen_w = w1_nopipe_wen_w | pipe_wen_w;

   //////////////////////////////////////////////////////////////////////
   // G port, load that lost W1, then restore, then mul/div
   //////////////////////////////////////////////////////////////////////

   assign sel_load_g    = wb_m & ld_g2;
   assign sel_restore_g = restore_req & (wb_m ^ ld_g2);
   assign sel_md_g      = ~(sel_load_g | sel_restore_g);

   assign md_rd_g  = md_sel_div ? md_div_rd_g  : md_mul_rd_g;
   assign md_tid_g = md_sel_div ? md_div_tid_g : md_mul_tid_g;

   assign w2_rd_g  = sel_load_g ? ld_rd_g2  : (sel_restore_g ? restore_rd  : md_rd_g);
   assign w2_tid_g = sel_load_g ? ld_tid_g2 : (sel_restore_g ? restore_tid : md_tid_g);

   assign w2_wen_g = (sel_load_g & ld_wen_g2) |
                     (sel_restore_g & restore_wen) |
                     (sel_md_g & md_req_g);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         w2_wen_w2 <= 1'b0;
      end else begin
         w2_wen_w2 <= w2_wen_g;
      end
   end

   // requester keeps its fields until it sees this high
   assign md_ack_g = sel_md_g;

   assign restore_pick = sel_restore_m | sel_restore_g;

   //////////////////////////////////////////////////////////////////////
   // completion to the thread scheduler
   //////////////////////////////////////////////////////////////////////

   assign md_done_g     = (md_req_g & md_ack_g) ? (thr_mask_t'(1) << md_tid_g) : '0;
   assign longop_done_g = md_done_g | restore_done;

endmodule : wb_port_arbiter

`default_nettype wire

/* design/wb_restore_fsm.sv */
// restore FSM that follows a restore from E to W and waits until a write port picks it
`timescale 1ns/1ps
`default_nettype none

module wb_restore_fsm import wb_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  logic      restore_e,
   input  logic      wb_e,
   input  logic      inst_vld_e,
   input  logic      inst_vld_w,
   input  logic      flush_w,
   input  reg_addr_t rd_m,
   input  tid_t      tid_m,
   input  logic      restore_pick,
   output logic      restore_req,
   output logic      restore_wen,
   output reg_addr_t restore_rd,
   output tid_t      restore_tid,
   output thr_mask_t restore_done
);

   restore_state_t state;
   restore_state_t state_nxt;
   logic           vld_restore_e;

   // only a restore that also writes a register needs tracking
   assign vld_restore_e = restore_e & wb_e & inst_vld_e;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= rs_idle;
      end else begin
         state <= state_nxt;
      end
   end

   // next state and port request
   always_comb begin
      state_nxt   = state;
      restore_req = 1'b0;
      restore_wen = 1'b0;
      case (state)
         rs_idle: begin
            if (vld_restore_e) begin
               state_nxt = rs_m;
            end
         end
         rs_m: begin
            state_nxt = rs_w;
         end
         rs_w: begin
            // flush in W still lets the restore complete, it just writes nothing
            restore_req = 1'b1;
            restore_wen = inst_vld_w & ~flush_w;
            if (restore_pick) begin
               state_nxt = rs_idle;
            end else if (restore_wen) begin
               state_nxt = rs_ready;
            end else begin
               state_nxt = rs_idle;
            end
         end
         rs_ready: begin
            restore_req = 1'b1;
            restore_wen = 1'b1;
            if (restore_pick) begin
               state_nxt = rs_idle;
            end
         end
         default: state_nxt = rs_idle;
      endcase
   end

   // destination is sampled while the restore sits in M
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         restore_rd  <= '0;
         restore_tid <= '0;
      end else if (state == rs_m) begin
         restore_rd  <= rd_m;
         restore_tid <= tid_m;
      end
   end

   assign restore_done = (restore_pick & restore_req) ? (thr_mask_t'(1) << restore_tid) : '0;

endmodule : wb_restore_fsm

`default_nettype wire

/* tb.f */
design/wb_pkg.sv
design/wb_pipe_valid.sv
design/wb_load_stage.sv
design/wb_restore_fsm.sv
design/wb_port_arbiter.sv
design/wb_ctl_top.sv
tb/tb_clock_gen.sv
tb/wb_ctl_props.sv
tb/wb_ctl_tb.sv

/* tb/tb_clock_gen.sv */
// testbench clock and reset source, 100 ns clock with reset low for five cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // release on a falling edge so the first active edge sees a settled reset
   initial begin
      rst_n = 1'b0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule : tb_clock_gen

`default_nettype wire

/* tb/wb_ctl_props.sv */
// concurrent checks on restore done, G port enable after reset and mul/div ack
`timescale 1ns/1ps
`default_nettype none

module wb_ctl_props import wb_pkg::*; (
   input logic      clk,
   input logic      rst_n,
   input logic      wb_m,
   input logic      ld_g2,
   input logic      restore_req,
   input thr_mask_t restore_done,
   input logic      w2_wen_w2,
   input logic      md_ack_g
);

   int unsigned fail_count = 0;
   logic        g_to_load;
   logic        g_to_restore;

   // G port owners other than mul/div
   assign g_to_load    = wb_m & ld_g2;
   assign g_to_restore = restore_req & (wb_m ^ ld_g2);

   done_one_thread: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(restore_done))
   else begin
      fail_count++;
      $error("restore done has more than one thread bit set");
   end

   w2_quiet_after_reset: assert property (@(posedge clk)
      $rose(rst_n) |-> !w2_wen_w2)
   else begin
      fail_count++;
      $error("G port write enable high on the first cycle after reset");
   end

   no_ack_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
      (g_to_load | g_to_restore) |-> !md_ack_g)
   else begin
      fail_count++;
      $error("mul/div ack high while the G port carries a load or restore");
   end

endmodule : wb_ctl_props

bind wb_ctl_top wb_ctl_props u_props (
   .clk          (clk),
   .rst_n        (rst_n),
   .wb_m         (wb_m),
   .ld_g2        (ld_g2),
   .restore_req  (restore_req),
   .restore_done (restore_done),
   .w2_wen_w2    (w2_wen_w2),
   .md_ack_g     (md_ack_g)
);

`default_nettype wire

/* tb/wb_ctl_tb.sv */
// testbench for the writeback control with random stimulus checked against a cycle model
`timescale 1ns/1ps
`default_nettype none

module wb_ctl_tb import wb_pkg::*; ();

   localparam int RESET_CYCLES  = 5;
   localparam int TEST_CYCLES   = 2000;
   localparam int CLK_PERIOD_NS = 100;
   localparam int WATCHDOG_NS   = (RESET_CYCLES + TEST_CYCLES + 20) * CLK_PERIOD_NS;

   logic      clk;
   logic      rst_n;
   logic      wen_d;
   logic      kill_e;
   logic      inst_vld_e;
   logic      inst_vld_w;
   logic      flush_w;
   logic      restore_e;
   reg_addr_t rd_m;
   tid_t      tid_m;
   logic      ld_vld_g;
   reg_addr_t ld_rd_g;
   tid_t      ld_tid_g;
   logic      ld_miss_g2;
   logic      md_req_g;
   logic      md_sel_div;
   reg_addr_t md_div_rd_g;
   tid_t      md_div_tid_g;
   reg_addr_t md_mul_rd_g;
   tid_t      md_mul_tid_g;
   reg_addr_t w1_rd_m;
   tid_t      w1_tid_m;
   logic      w1_wen_w;
   reg_addr_t w2_rd_g;
   tid_t      w2_tid_g;
   logic      w2_wen_w2;
   logic      md_ack_g;
   thr_mask_t longop_done_g;

   // model state with one entry per flop of the write path
   logic           m_wb_e;
   logic           m_wb_m;
   logic           m_wb_w;
   logic           m_ld_g2;
   reg_addr_t      m_ld_rd_g2;
   tid_t           m_ld_tid_g2;
   restore_state_t m_rs_state;
   reg_addr_t      m_rs_rd;
   tid_t           m_rs_tid;
   logic           m_w1_np_wen;
   logic           m_w2_wen;

   // model results for the inputs now applied
   logic      exp_pipe_wen;
   logic      exp_ld_wen;
   logic      exp_rs_req;
   logic      exp_rs_wen;
   logic      exp_w1_load;
   logic      exp_w1_rs;
   logic      exp_g_load;
   logic      exp_g_rs;
   logic      exp_g_md;
   reg_addr_t exp_w1_rd;
   tid_t      exp_w1_tid;
   reg_addr_t exp_w2_rd;
   tid_t      exp_w2_tid;
   thr_mask_t exp_done;

   logic md_accepted;
   int   errors;
   int   rs_picks;
   int   rs_waits;
   int   g_loads;
   int   md_accepts;

   tb_clock_gen u_clock_gen (
      .clk   (clk),
      .rst_n (rst_n)
   );

   wb_ctl_top UUT (.*);

   //////////////////////////////////////////////////////////////////////
   // cycle model
   //////////////////////////////////////////////////////////////////////

   task automatic eval_model();
      exp_pipe_wen = m_wb_w && !flush_w && inst_vld_w;
      exp_ld_wen   = m_ld_g2 && !ld_miss_g2;
      exp_rs_req   = (m_rs_state == rs_w) || (m_rs_state == rs_ready);
      if (m_rs_state == rs_w) begin
         exp_rs_wen = inst_vld_w && !flush_w;
      end else begin
         exp_rs_wen = (m_rs_state == rs_ready);
      end
      // W1 goes pipe, load, restore in that order
      exp_w1_load = !m_wb_m && m_ld_g2;
      exp_w1_rs   = !m_wb_m && !m_ld_g2 && exp_rs_req;
      exp_g_load  = m_wb_m && m_ld_g2;
      exp_g_rs    = exp_rs_req && (m_wb_m != m_ld_g2);
      exp_g_md    = !exp_g_load && !exp_g_rs;
      if (m_wb_m) begin
         exp_w1_rd  = rd_m;
         exp_w1_tid = tid_m;
      end else if (m_ld_g2) begin
         exp_w1_rd  = m_ld_rd_g2;
         exp_w1_tid = m_ld_tid_g2;
      end else begin
         exp_w1_rd  = m_rs_rd;
         exp_w1_tid = m_rs_tid;
      end
      if (exp_g_load) begin
         exp_w2_rd  = m_ld_rd_g2;
         exp_w2_tid = m_ld_tid_g2;
      end else if (exp_g_rs) begin
         exp_w2_rd  = m_rs_rd;
         exp_w2_tid = m_rs_tid;
      end else begin
         exp_w2_rd  = md_sel_div ? md_div_rd_g : md_mul_rd_g;
         exp_w2_tid = md_sel_div ? md_div_tid_g : md_mul_tid_g;
      end
      exp_done = '0;
      if (exp_g_md && md_req_g) begin
         exp_done[exp_w2_tid] = 1'b1;
      end
      if (exp_w1_rs || exp_g_rs) begin
         exp_done[m_rs_tid] = 1'b1;
      end
   endtask

   // apply the rising edge that has just passed
   task automatic step_model();
      logic pick;
      eval_model();
      pick        = exp_w1_rs || exp_g_rs;
      md_accepted = md_req_g && exp_g_md;
      rs_picks    += int'(pick);
      g_loads     += int'(exp_g_load);
      md_accepts  += int'(md_accepted);
      m_w1_np_wen = (exp_w1_load && exp_ld_wen) || (exp_w1_rs && exp_rs_wen);
      if (exp_g_load) begin
         m_w2_wen = exp_ld_wen;
      end else if (exp_g_rs) begin
         m_w2_wen = exp_rs_wen;
      end else begin
         m_w2_wen = md_req_g;
      end
      case (m_rs_state)
         rs_idle: begin
            if (restore_e && m_wb_e && inst_vld_e) begin
               m_rs_state = rs_m;
            end
         end
         rs_m: begin
            m_rs_rd    = rd_m;
            m_rs_tid   = tid_m;
            m_rs_state = rs_w;
         end
         rs_w: begin
            if (!pick && exp_rs_wen) begin
               rs_waits++;
               m_rs_state = rs_ready;
            end else begin
               m_rs_state = rs_idle;
            end
         end
         default: begin
            if (pick) begin
               m_rs_state = rs_idle;
            end
         end
      endcase
      m_wb_w      = m_wb_m;
      m_wb_m      = m_wb_e && !kill_e && !restore_e;
      m_wb_e      = wen_d;
      m_ld_g2     = ld_vld_g;
      m_ld_rd_g2  = ld_rd_g;
      m_ld_tid_g2 = ld_tid_g;
   endtask

   //////////////////////////////////////////////////////////////////////
   // checks and stimulus
   //////////////////////////////////////////////////////////////////////

   task automatic check_val(input string name, input logic [7:0] exp_v,
                            input logic [7:0] act_v);
      assert (act_v === exp_v) else begin
         errors++;
         $display("Error: %s expected %h actual %h at %0t", name, exp_v, act_v, $time);
      end
   endtask

   task automatic check_outputs();
      eval_model();
      check_val("w1_wen_w", 8'(m_w1_np_wen || exp_pipe_wen), 8'(w1_wen_w));
      check_val("w2_wen_w2", 8'(m_w2_wen), 8'(w2_wen_w2));
      check_val("md_ack_g", 8'(exp_g_md), 8'(md_ack_g));
      check_val("longop_done_g", 8'(exp_done), 8'(longop_done_g));
      check_val("w2_rd_g", 8'(exp_w2_rd), 8'(w2_rd_g));
      check_val("w2_tid_g", 8'(exp_w2_tid), 8'(w2_tid_g));
      // W1 fields only mean something while a source owns the port
      if (m_wb_m || m_ld_g2 || exp_rs_req) begin
         check_val("w1_rd_m", 8'(exp_w1_rd), 8'(w1_rd_m));
         check_val("w1_tid_m", 8'(exp_w1_tid), 8'(w1_tid_m));
      end
   endtask

   task automatic drive_inputs(input logic quiet);
      wen_d      = !quiet && ($urandom_range(99, 0) < 60);
      kill_e     = ($urandom_range(99, 0) < 10);
      inst_vld_e = ($urandom_range(99, 0) < 90);
      inst_vld_w = ($urandom_range(99, 0) < 90);
      flush_w    = ($urandom_range(99, 0) < 10);
      rd_m       = reg_addr_t'($urandom);
      tid_m      = tid_t'($urandom);
      // one restore at a time
      restore_e  = !quiet && (m_rs_state == rs_idle) && ($urandom_range(99, 0) < 20);
      ld_vld_g   = !quiet && ($urandom_range(99, 0) < 35);
      ld_rd_g    = reg_addr_t'($urandom);
      ld_tid_g   = tid_t'($urandom);
      ld_miss_g2 = ($urandom_range(99, 0) < 20);
      // a request and its fields stay put until acked
      if (!md_req_g || md_accepted) begin
         md_req_g     = !quiet && ($urandom_range(99, 0) < 40);
         md_sel_div   = ($urandom_range(99, 0) < 50);
         md_div_rd_g  = reg_addr_t'($urandom);
         md_div_tid_g = tid_t'($urandom);
         md_mul_rd_g  = reg_addr_t'($urandom);
         md_mul_tid_g = tid_t'($urandom);
      end
   endtask

   task automatic run_cycle(input logic quiet);
      @(negedge clk);
      step_model();
      check_outputs();
      drive_inputs(quiet);
   endtask

   task automatic check_coverage();
      assert (rs_picks > 0) else begin
         errors++;
         $display("no restore was ever picked by a write port");
      end
      assert (rs_waits > 0) else begin
         errors++;
         $display("no restore ever had to wait for a free port");
      end
      assert (g_loads > 0) else begin
         errors++;
         $display("no load was ever written through the G port");
      end
      assert (md_accepts > 0) else begin
         errors++;
         $display("no mul/div request was ever accepted");
      end
   endtask

   initial begin
      void'($urandom(14));
      errors      = 0;
      rs_picks    = 0;
      rs_waits    = 0;
      g_loads     = 0;
      md_accepts  = 0;
      md_accepted = 1'b0;
      {wen_d, kill_e, inst_vld_e, inst_vld_w, flush_w, restore_e} = '0;
      rd_m         = '0;
      tid_m        = '0;
      {ld_vld_g, ld_miss_g2, md_req_g, md_sel_div} = '0;
      ld_rd_g      = '0;
      ld_tid_g     = '0;
      md_div_rd_g  = '0;
      md_div_tid_g = '0;
      md_mul_rd_g  = '0;
      md_mul_tid_g = '0;
      {m_wb_e, m_wb_m, m_wb_w, m_ld_g2, m_w1_np_wen, m_w2_wen} = '0;
      m_ld_rd_g2  = '0;
      m_ld_tid_g2 = '0;
      m_rs_state  = rs_idle;
      m_rs_rd     = '0;
      m_rs_tid    = '0;

      @(posedge rst_n);
      // all enables and done must be low straight out of reset
      check_outputs();
      drive_inputs(1'b0);
      repeat (TEST_CYCLES) run_cycle(1'b0);

      // stop new work and let a held mul/div request or restore finish
      while (md_req_g || m_rs_state != rs_idle) begin
         run_cycle(1'b1);
      end
      run_cycle(1'b1);
      check_coverage();

      errors = errors + int'(UUT.u_props.fail_count);
      $display("total errors: %0d", errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   initial begin
      #WATCHDOG_NS;
      $display("watchdog expired before the test finished");
      $display("total errors: %0d", errors);
      $display("Errors found");
      $finish;
   end

endmodule : wb_ctl_tb

`default_nettype wire
